//--- hw/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// datapath and field widths
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_OPCODE_W    7
`define RV_FUNCT3_W    3
`define RV_FUNCT7_W    7

// lsb positions of the instruction fields
`define RV_OPCODE_LSB  0
`define RV_RD_LSB      7
`define RV_FUNCT3_LSB  12
`define RV_RS1_LSB     15
`define RV_RS2_LSB     20
`define RV_FUNCT7_LSB  25

`endif

//--- hw/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RV_OPCODE_W-1:0]   opcode_t;
    typedef logic [`RV_FUNCT3_W-1:0]   funct3_t;
    typedef logic [`RV_FUNCT7_W-1:0]   funct7_t;

    // major opcodes
    localparam opcode_t OPC_ALU_IMM = 7'b0010011;
    localparam opcode_t OPC_ALU_REG = 7'b0110011;
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_AUIPC   = 7'b0010111;
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_JAL     = 7'b1101111;

    // alu group funct3
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch funct3, 2 and 3 are undefined
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct7_t F7_NORMAL = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    typedef enum logic {
        RS1 = 1'b0,
        PC  = 1'b1
    } op_a_sel_e;

    typedef enum logic {
        RS2 = 1'b0,
        IMM = 1'b1
    } op_b_sel_e;

    typedef enum logic [1:0] {
        ALU      = 2'd0,
        MEM      = 2'd1,
        PC_PLUS4 = 2'd2
    } wb_sel_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        BEQ  = 3'd1,
        BNE  = 3'd2,
        BLT  = 3'd3,
        BGE  = 3'd4,
        BLTU = 3'd5,
        BGEU = 3'd6,
        JUMP = 3'd7
    } jump_kind_e;

endpackage

//--- hw/alu_dec_if.sv
`timescale 1ns/1ns

interface alu_dec_if
    import rv_decode_pkg::*;
();

    funct3_t funct3;
    funct7_t funct7;
    // high for the register-immediate group
    logic    is_imm;
    alu_op_e alu_op;
    logic    legal;

    modport opcode_decoder (
        output funct3, funct7, is_imm,
        input  alu_op, legal
    );

    modport alu_op_decoder (
        input  funct3, funct7, is_imm,
        output alu_op, legal
    );

endinterface

//--- hw/alu_op_decoder.sv
`timescale 1ns/1ns

module alu_op_decoder
    import rv_decode_pkg::*;
(
    alu_dec_if.alu_op_decoder alu
);

    logic f7_normal;
    logic f7_alt;
    // funct7 must be zero here, unless it is an immediate
    logic f7_ok;

    assign f7_normal = (alu.funct7 == F7_NORMAL);
    assign f7_alt    = (alu.funct7 == F7_ALT);
    assign f7_ok     = alu.is_imm || f7_normal;

    always_comb begin
        alu.alu_op = ADD;
        alu.legal  = 1'b1;

        case (alu.funct3)
            F3_ADD_SUB: begin
                // no subi, funct7 is immediate data
                if (alu.is_imm || f7_normal) begin
                    alu.alu_op = ADD;
                end else if (f7_alt) begin
                    alu.alu_op = SUB;
                end else begin
                    alu.legal = 1'b0;
                end
            end
            F3_SLL: begin
                // shamt only, checked in both forms
                alu.alu_op = SLL;
                alu.legal  = f7_normal;
            end
            F3_SLT: begin
                alu.alu_op = SLT;
                alu.legal  = f7_ok;
            end
            F3_SLTU: begin
                alu.alu_op = SLTU;
                alu.legal  = f7_ok;
            end
            F3_XOR: begin
                alu.alu_op = XOR;
                alu.legal  = f7_ok;
            end
            F3_SRL_SRA: begin
                if (f7_normal) begin
                    alu.alu_op = SRL;
                end else if (f7_alt) begin
                    alu.alu_op = SRA;
                end else begin
                    alu.legal = 1'b0;
                end
            end
            F3_OR: begin
                alu.alu_op = OR;
                alu.legal  = f7_ok;
            end
            F3_AND: begin
                alu.alu_op = AND;
                alu.legal  = f7_ok;
            end
            default: begin
                alu.legal = 1'b0;
            end
        endcase

        // illegal encodings report add
        if (!alu.legal) begin
            alu.alu_op = ADD;
        end
    end

endmodule

//--- hw/opcode_decoder.sv
`timescale 1ns/1ns

`include "rv_decode_settings.svh"

module opcode_decoder
    import rv_decode_pkg::*;
(
    input  word_t              instr_i,
    alu_dec_if.opcode_decoder  alu,
    output reg_addr_t          rs1_addr_o,
    output reg_addr_t          rs2_addr_o,
    output reg_addr_t          rd_addr_o,
    output logic               write_enable_o,
    output op_a_sel_e          op_a_sel_o,
    output op_b_sel_e          op_b_sel_o,
    output alu_op_e            alu_op_o,
    output wb_sel_e            wb_sel_o,
    output logic               store_o,
    output jump_kind_e         jump_kind_o,
    output logic               illegal_o
);

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rs1_f;
    reg_addr_t rs2_f;
    reg_addr_t rd_f;
    logic      legal;

    // fixed field positions for every format used here
    assign opcode = instr_i[`RV_OPCODE_LSB +: `RV_OPCODE_W];
    assign rd_f   = instr_i[`RV_RD_LSB +: `RV_REG_ADDR_W];
    assign funct3 = instr_i[`RV_FUNCT3_LSB +: `RV_FUNCT3_W];
    assign rs1_f  = instr_i[`RV_RS1_LSB +: `RV_REG_ADDR_W];
    assign rs2_f  = instr_i[`RV_RS2_LSB +: `RV_REG_ADDR_W];
    assign funct7 = instr_i[`RV_FUNCT7_LSB +: `RV_FUNCT7_W];

    assign alu.funct3 = funct3;
    assign alu.funct7 = funct7;
    assign alu.is_imm = (opcode == OPC_ALU_IMM);

    always_comb begin
        legal          = 1'b1;
        rs1_addr_o     = rs1_f;
        rs2_addr_o     = rs2_f;
        rd_addr_o      = rd_f;
        write_enable_o = 1'b0;
        op_a_sel_o     = RS1;
        op_b_sel_o     = RS2;
        alu_op_o       = ADD;
        wb_sel_o       = ALU;
        store_o        = 1'b0;
        jump_kind_o    = NONE;

        case (opcode)
            OPC_ALU_IMM: begin
                write_enable_o = 1'b1;
                op_b_sel_o     = IMM;
                alu_op_o       = alu.alu_op;
                legal          = alu.legal;
            end
            OPC_ALU_REG: begin
                write_enable_o = 1'b1;
                alu_op_o       = alu.alu_op;
                legal          = alu.legal;
            end
            OPC_LUI: begin
                // x0 + imm
                write_enable_o = 1'b1;
                op_b_sel_o     = IMM;
                rs1_addr_o     = '0;
            end
            OPC_AUIPC: begin
                write_enable_o = 1'b1;
                op_a_sel_o     = PC;
                op_b_sel_o     = IMM;
            end
            OPC_LOAD: begin
                write_enable_o = 1'b1;
                op_b_sel_o     = IMM;
                wb_sel_o       = MEM;
            end
            OPC_STORE: begin
                op_b_sel_o = IMM;
                store_o    = 1'b1;
            end
            OPC_BRANCH: begin
                // alu forms the target, rs1/rs2 go to the comparator
                op_a_sel_o = PC;
                op_b_sel_o = IMM;
                case (funct3)
                    F3_BEQ:  jump_kind_o = BEQ;
                    F3_BNE:  jump_kind_o = BNE;
                    F3_BLT:  jump_kind_o = BLT;
                    F3_BGE:  jump_kind_o = BGE;
                    F3_BLTU: jump_kind_o = BLTU;
                    F3_BGEU: jump_kind_o = BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                write_enable_o = 1'b1;
                op_a_sel_o     = PC;
                op_b_sel_o     = IMM;
                wb_sel_o       = PC_PLUS4;
                jump_kind_o    = JUMP;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // anything illegal becomes x0 + x0 without write
        if (!legal) begin
            rs1_addr_o     = '0;
            rs2_addr_o     = '0;
            rd_addr_o      = '0;
            write_enable_o = 1'b0;
            op_a_sel_o     = RS1;
            op_b_sel_o     = RS2;
            alu_op_o       = ADD;
            wb_sel_o       = ALU;
            store_o        = 1'b0;
            jump_kind_o    = NONE;
        end

        illegal_o = !legal;
    end

endmodule

//--- hw/rv_decode_stage.sv
`timescale 1ns/1ns

module rv_decode_stage
    import rv_decode_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       valid_i,
    input  word_t      pc_i,
    input  word_t      instr_i,
    output logic       valid_o,
    output word_t      pc_o,
    output word_t      instr_o,
    output reg_addr_t  rs1_addr_o,
    output reg_addr_t  rs2_addr_o,
    output reg_addr_t  rd_addr_o,
    output logic       write_enable_o,
    output op_a_sel_e  op_a_sel_o,
    output op_b_sel_e  op_b_sel_o,
    output alu_op_e    alu_op_o,
    output wb_sel_e    wb_sel_o,
    output logic       store_o,
    output jump_kind_e jump_kind_o,
    output logic       illegal_o
);

    reg_addr_t  dec_rs1;
    reg_addr_t  dec_rs2;
    reg_addr_t  dec_rd;
    logic       dec_we;
    op_a_sel_e  dec_a_sel;
    op_b_sel_e  dec_b_sel;
    alu_op_e    dec_alu_op;
    wb_sel_e    dec_wb_sel;
    logic       dec_store;
    jump_kind_e dec_jump_kind;
    logic       dec_illegal;

    logic       we_q;
    logic       store_q;

    alu_dec_if u_alu_if ();

    opcode_decoder u_opcode_dec (
        .instr_i        (instr_i),
        .alu            (u_alu_if.opcode_decoder),
        .rs1_addr_o     (dec_rs1),
        .rs2_addr_o     (dec_rs2),
        .rd_addr_o      (dec_rd),
        .write_enable_o (dec_we),
        .op_a_sel_o     (dec_a_sel),
        .op_b_sel_o     (dec_b_sel),
        .alu_op_o       (dec_alu_op),
        .wb_sel_o       (dec_wb_sel),
        .store_o        (dec_store),
        .jump_kind_o    (dec_jump_kind),
        .illegal_o      (dec_illegal)
    );

    alu_op_decoder u_alu_op_dec (
        .alu (u_alu_if.alu_op_decoder)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o   <= 1'b0;
            we_q      <= 1'b0;
            store_q   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                we_q      <= dec_we;
                store_q   <= dec_store;
                illegal_o <= dec_illegal;
            end
        end
    end

    // decoded record held between strobes
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            pc_o        <= pc_i;
            instr_o     <= instr_i;
            rs1_addr_o  <= dec_rs1;
            rs2_addr_o  <= dec_rs2;
            rd_addr_o   <= dec_rd;
            op_a_sel_o  <= dec_a_sel;
            op_b_sel_o  <= dec_b_sel;
            alu_op_o    <= dec_alu_op;
            wb_sel_o    <= dec_wb_sel;
            jump_kind_o <= dec_jump_kind;
        end
    end

    // side effects only in the valid cycle
    assign write_enable_o = valid_o & we_q;
    assign store_o        = valid_o & store_q;

    a_no_we_and_store : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o |-> !(write_enable_o && store_o))
        else $error("write and store together");

    a_illegal_is_nop : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        illegal_o |-> !write_enable_o && !store_o && (jump_kind_o == NONE))
        else $error("illegal instruction with side effects");

endmodule

//--- verif/rv_decode_tb.sv
`timescale 1ns/1ns

module rv_decode_tb
    import rv_decode_pkg::*;
();

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 5;

    logic       clk_i;
    logic       arst_n_i;
    logic       valid_i;
    word_t      pc_i;
    word_t      instr_i;
    logic       valid_o;
    word_t      pc_o;
    word_t      instr_o;
    reg_addr_t  rs1_addr_o;
    reg_addr_t  rs2_addr_o;
    reg_addr_t  rd_addr_o;
    logic       write_enable_o;
    op_a_sel_e  op_a_sel_o;
    op_b_sel_e  op_b_sel_o;
    alu_op_e    alu_op_o;
    wb_sel_e    wb_sel_o;
    logic       store_o;
    jump_kind_e jump_kind_o;
    logic       illegal_o;

    // expected values, one entry per vector line
    word_t      exp_pc [MAX_VEC];
    word_t      exp_instr [MAX_VEC];
    reg_addr_t  exp_rs1 [MAX_VEC];
    reg_addr_t  exp_rs2 [MAX_VEC];
    reg_addr_t  exp_rd [MAX_VEC];
    logic       exp_we [MAX_VEC];
    op_a_sel_e  exp_a_sel [MAX_VEC];
    op_b_sel_e  exp_b_sel [MAX_VEC];
    alu_op_e    exp_alu_op [MAX_VEC];
    wb_sel_e    exp_wb_sel [MAX_VEC];
    logic       exp_store [MAX_VEC];
    jump_kind_e exp_jump [MAX_VEC];
    logic       exp_illegal [MAX_VEC];

    int num_vec = 0;
    int cycle = 0;
    int sent = 0;
    int checked = 0;
    int mismatches = 0;
    int failures = 0;
    // outstanding strobes, vector index and the cycle it was presented in
    int pend_idx [$];
    int pend_cyc [$];

    rv_decode_stage dut (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_vector(input int i);
        compare_field("pc_o", pc_o, exp_pc[i]);
        compare_field("instr_o", instr_o, exp_instr[i]);
        compare_field("rs1_addr_o", rs1_addr_o, exp_rs1[i]);
        compare_field("rs2_addr_o", rs2_addr_o, exp_rs2[i]);
        compare_field("rd_addr_o", rd_addr_o, exp_rd[i]);
        compare_field("write_enable_o", write_enable_o, exp_we[i]);
        compare_field("op_a_sel_o", op_a_sel_o, exp_a_sel[i]);
        compare_field("op_b_sel_o", op_b_sel_o, exp_b_sel[i]);
        compare_field("alu_op_o", alu_op_o, exp_alu_op[i]);
        compare_field("wb_sel_o", wb_sel_o, exp_wb_sel[i]);
        compare_field("store_o", store_o, exp_store[i]);
        compare_field("jump_kind_o", jump_kind_o, exp_jump[i]);
        compare_field("illegal_o", illegal_o, exp_illegal[i]);
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [31:0] c [13];
        fd = $fopen("verif/rv_decode_vectors.txt", "r");
        assert (fd != 0) else begin
            failures++;
            $display("could not open verif/rv_decode_vectors.txt");
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", c[0], c[1],
                            c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10], c[11], c[12]);
                assert (n == 13) else begin
                    failures++;
                    $display("malformed vector line: %s", line);
                end
                if (n == 13) begin
                    exp_pc[num_vec]      = c[0];
                    exp_instr[num_vec]   = c[1];
                    exp_rs1[num_vec]     = c[2][4:0];
                    exp_rs2[num_vec]     = c[3][4:0];
                    exp_rd[num_vec]      = c[4][4:0];
                    exp_we[num_vec]      = c[5][0];
                    exp_a_sel[num_vec]   = op_a_sel_e'(c[6][0]);
                    exp_b_sel[num_vec]   = op_b_sel_e'(c[7][0]);
                    exp_alu_op[num_vec]  = alu_op_e'(c[8][3:0]);
                    exp_wb_sel[num_vec]  = wb_sel_e'(c[9][1:0]);
                    exp_store[num_vec]   = c[10][0];
                    exp_jump[num_vec]    = jump_kind_e'(c[11][2:0]);
                    exp_illegal[num_vec] = c[12][0];
                    num_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_vector(input int i);
        @(posedge clk_i);
        valid_i <= 1'b1;
        pc_i    <= exp_pc[i];
        instr_i <= exp_instr[i];
        pend_idx.push_back(i);
        pend_cyc.push_back(cycle + 1);
        sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            valid_i <= 1'b0;
        end
    endtask

    // results are compared mid-cycle, away from the active edge
    always @(negedge clk_i) begin
        int idx;
        int issued;
        if (arst_n_i) begin
            if (valid_o) begin
                assert (pend_idx.size() != 0) else begin
                    failures++;
                    $display("valid_o high at %0t with no instruction outstanding", $time);
                end
                if (pend_idx.size() != 0) begin
                    idx = pend_idx.pop_front();
                    issued = pend_cyc.pop_front();
                    compare_field("result cycle", cycle, issued + 1);
                    check_vector(idx);
                    checked++;
                end
            end else begin
                compare_field("write_enable_o while idle", write_enable_o, 1'b0);
                compare_field("store_o while idle", store_o, 1'b0);
                if (pend_idx.size() != 0 && cycle > pend_cyc[0] + TIMEOUT) begin
                    failures++;
                    $display("valid_o never arrived for vector %0d", pend_idx[0]);
                    void'(pend_idx.pop_front());
                    void'(pend_cyc.pop_front());
                end
            end
        end
    end

    initial begin
        logic [31:0] seed;
        int wait_cnt;
        seed = 32'd60;
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        valid_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        load_vectors();
        assert (num_vec > 0) else begin
            failures++;
            $display("no vectors were loaded");
        end

        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        compare_field("valid_o after reset", valid_o, 1'b0);
        compare_field("write_enable_o after reset", write_enable_o, 1'b0);
        compare_field("store_o after reset", store_o, 1'b0);
        compare_field("illegal_o after reset", illegal_o, 1'b0);

        // every vector once, with zero to three idle cycles between strobes
        for (int i = 0; i < num_vec; i++) begin
            send_vector(i);
            seed = xorshift(seed);
            idle_cycles(int'(seed[1:0]));
        end
        idle_cycles(2);
        // eight strobes back to back
        for (int i = 0; i < 8 && i < num_vec; i++) begin
            send_vector(i);
        end
        idle_cycles(1);

        wait_cnt = 0;
        while (pend_idx.size() != 0 && wait_cnt < TIMEOUT + 2) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        @(posedge clk_i);
        assert (pend_idx.size() == 0 && checked == sent) else begin
            failures++;
            $display("only %0d of %0d results arrived", checked, sent);
        end

        $display("errors: %0d mismatches, %0d other failures, %0d results checked",
                 mismatches, failures, checked);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/rv_decode_pkg.sv
hw/alu_dec_if.sv
hw/alu_op_decoder.sv
hw/opcode_decoder.sv
hw/rv_decode_stage.sv
verif/rv_decode_tb.sv

//--- verif/rv_decode_vectors.txt
# pc instr rs1 rs2 rd we a_sel b_sel alu_op wb_sel store jump_kind illegal (hex, enums as codes)
00000000 003100B3 02 03 01 1 0 0 0 0 0 0 0
00000004 403100B3 02 03 01 1 0 0 1 0 0 0 0
00000008 003110B3 02 03 01 1 0 0 2 0 0 0 0
0000000C 003120B3 02 03 01 1 0 0 3 0 0 0 0
00000010 003130B3 02 03 01 1 0 0 4 0 0 0 0
00000014 003140B3 02 03 01 1 0 0 5 0 0 0 0
00000018 003150B3 02 03 01 1 0 0 6 0 0 0 0
0000001C 403150B3 02 03 01 1 0 0 7 0 0 0 0
00000020 003160B3 02 03 01 1 0 0 8 0 0 0 0
00000024 003170B3 02 03 01 1 0 0 9 0 0 0 0
00000028 40028313 05 00 06 1 0 1 0 0 0 0 0
0000002C 1232A313 05 03 06 1 0 1 3 0 0 0 0
00000030 FFF2B313 05 1F 06 1 0 1 4 0 0 0 0
00000034 0F02C313 05 10 06 1 0 1 5 0 0 0 0
00000038 0552E313 05 15 06 1 0 1 8 0 0 0 0
0000003C 0FF2F313 05 1F 06 1 0 1 9 0 0 0 0
00000040 00429313 05 04 06 1 0 1 2 0 0 0 0
00000044 0072D313 05 07 06 1 0 1 6 0 0 0 0
00000048 4072D313 05 07 06 1 0 1 7 0 0 0 0
0000004C 123453B7 00 03 07 1 0 1 0 0 0 0 0
00000050 00010417 02 00 08 1 1 1 0 0 0 0 0
00000054 00852483 0A 08 09 1 0 1 0 1 0 0 0
00000058 00B62623 0C 0B 0C 0 0 1 0 0 1 0 0
0000005C 010000EF 00 10 01 1 1 1 0 2 0 7 0
00000060 00310463 02 03 08 0 1 1 0 0 0 1 0
00000064 00311463 02 03 08 0 1 1 0 0 0 2 0
00000068 00314463 02 03 08 0 1 1 0 0 0 3 0
0000006C 00315463 02 03 08 0 1 1 0 0 0 4 0
00000070 00316463 02 03 08 0 1 1 0 0 0 5 0
00000074 00317463 02 03 08 0 1 1 0 0 0 6 0
00000078 00312463 00 00 00 0 0 0 0 0 0 0 1
0000007C 00313463 00 00 00 0 0 0 0 0 0 0 1
00000080 023100B3 00 00 00 0 0 0 0 0 0 0 1
00000084 40429313 00 00 00 0 0 0 0 0 0 0 1
00000088 000100E7 00 00 00 0 0 0 0 0 0 0 1
0000008C 0FF0000F 00 00 00 0 0 0 0 0 0 0 1
00000090 403120B3 00 00 00 0 0 0 0 0 0 0 1
